/* common/periph_pkg.sv */
// ---------------------------------------------------------------------
// Shared definitions for the peripheral subsystem
// Bus widths, region and offset types, interrupt priority type
// Register address map of the interrupt controller and the timers
// ---------------------------------------------------------------------

package periph_pkg;

    // Bus types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  region_t;  // Address bits 15:12
    typedef logic [11:0] offset_t;  // Address bits 11:0

    // Priority 0 never interrupts
    typedef logic [2:0] prio_t;

    // ---------------------------------------------------------------------
    // Region map
    // ---------------------------------------------------------------------
    localparam region_t RegionPlic  = 4'd0;
    localparam region_t RegionTimer = 4'd1;

    // ---------------------------------------------------------------------
    // Interrupt controller offsets
    // ---------------------------------------------------------------------
    // Source priorities at 4*s for source ID s
    localparam offset_t PlicPendingOffs = 12'h080;  // Bit s is source ID s
    localparam offset_t PlicEnableOffs  = 12'h100;  // Plus 4*t
    localparam offset_t PlicThreshOffs  = 12'h200;  // Plus 8*t
    localparam offset_t PlicClaimOffs   = 12'h204;  // Plus 8*t

    // ---------------------------------------------------------------------
    // Timer offsets
    // ---------------------------------------------------------------------
    localparam int      TimerStride    = 16;  // Bytes between timers
    localparam offset_t TimerCountOffs = 12'h000;
    localparam offset_t TimerCmpOffs   = 12'h004;
    localparam offset_t TimerCtrlOffs  = 12'h008;

    // Read data of an unmapped region
    localparam data_t ErrData = 32'hDEAD_BEEF;

endpackage

/* plic/plic_target.sv */
// ---------------------------------------------------------------------
// Interrupt controller target
// Highest priority pending and enabled source above the threshold
// Lowest ID wins a tie, ID 0 when nothing qualifies
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module plic_target #(
    parameter int NumSources = 4
) (
    input  periph_pkg::prio_t [NumSources-1:0] prio_i,
    input  logic [NumSources-1:0]              pending_i,
    input  logic [NumSources-1:0]              enable_i,
    input  periph_pkg::prio_t                  threshold_i,
    output periph_pkg::data_t                  claim_id_o,
    output logic                               eip_o
);
    import periph_pkg::*;

    prio_t best_prio;
    data_t best_id;

    // Scan upwards, strict compare keeps the lowest ID on a tie
    always_comb begin
        best_prio = threshold_i;  // Must beat the threshold
        best_id   = '0;
        for (int i = 0; i < NumSources; i++) begin
            if (pending_i[i] && enable_i[i] && prio_i[i] > best_prio) begin
                best_prio = prio_i[i];
                best_id   = data_t'(i + 1);
            end
        end
    end

    assign claim_id_o = best_id;
    assign eip_o      = (best_id != '0);

endmodule

/* plic/plic_regs.sv */
// ---------------------------------------------------------------------
// Interrupt controller register file
// Source priorities, level gateways, pending and in-service state
// Per-target enable, threshold and claim/complete
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module plic_regs #(
    parameter int NumSources = 4,
    parameter int NumTargets = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  sel_i,
    input  periph_pkg::offset_t   offset_i,
    input  logic                  write_i,
    input  periph_pkg::data_t     wdata_i,
    input  logic [NumSources-1:0] irq_src_i,
    output periph_pkg::data_t     rdata_o,
    output logic [NumTargets-1:0] eip_o
);
    import periph_pkg::*;

    // Index i holds source ID i+1
    prio_t [NumSources-1:0]                 prio_q;
    logic  [NumSources-1:0]                 pending_q;
    logic  [NumSources-1:0]                 in_service_q;
    logic  [NumTargets-1:0][NumSources-1:0] enable_q;
    prio_t [NumTargets-1:0]                 thresh_q;
    data_t [NumTargets-1:0]                 claim_id;

    logic [NumSources-1:0] prio_hit;
    logic                  pending_hit;
    logic [NumTargets-1:0] enable_hit;
    logic [NumTargets-1:0] thresh_hit;
    logic [NumTargets-1:0] claim_hit;
    logic [NumSources-1:0] claim_clr;
    logic [NumSources-1:0] complete;
    logic                  wr_en;
    logic                  rd_en;

    assign wr_en = sel_i && write_i;
    assign rd_en = sel_i && !write_i;

    // ---------------------------------------------------------------------
    // Offset match
    // ---------------------------------------------------------------------
    always_comb begin
        pending_hit = (offset_i == PlicPendingOffs);
        for (int i = 0; i < NumSources; i++) begin
            prio_hit[i] = (offset_i == offset_t'(4 * (i + 1)));
        end
        for (int t = 0; t < NumTargets; t++) begin
            enable_hit[t] = (offset_i == PlicEnableOffs + offset_t'(4 * t));
            thresh_hit[t] = (offset_i == PlicThreshOffs + offset_t'(8 * t));
            claim_hit[t]  = (offset_i == PlicClaimOffs + offset_t'(8 * t));
        end
    end

    // Unknown offsets read 0
    always_comb begin
        rdata_o = '0;
        if (pending_hit) rdata_o = data_t'({pending_q, 1'b0});
        for (int i = 0; i < NumSources; i++) begin
            if (prio_hit[i]) rdata_o = data_t'(prio_q[i]);
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (enable_hit[t]) rdata_o = data_t'({enable_q[t], 1'b0});
            if (thresh_hit[t]) rdata_o = data_t'(thresh_q[t]);
            if (claim_hit[t])  rdata_o = claim_id[t];
        end
    end

    // Claim on read, complete on write of the ID
    always_comb begin
        claim_clr = '0;
        complete  = '0;
        for (int t = 0; t < NumTargets; t++) begin
            for (int i = 0; i < NumSources; i++) begin
                if (rd_en && claim_hit[t] && claim_id[t] == data_t'(i + 1)) claim_clr[i] = 1'b1;
                if (wr_en && claim_hit[t] && wdata_i == data_t'(i + 1))     complete[i]  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q       <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            enable_q     <= '0;
            thresh_q     <= '0;
        end else begin
            // Level gateway, no new request while in service
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_clr;
            in_service_q <= (in_service_q | claim_clr) & ~complete;
            if (wr_en) begin
                for (int i = 0; i < NumSources; i++) begin
                    if (prio_hit[i]) prio_q[i] <= wdata_i[$bits(prio_t)-1:0];
                end
                for (int t = 0; t < NumTargets; t++) begin
                    if (enable_hit[t]) enable_q[t] <= wdata_i[NumSources:1];
                    if (thresh_hit[t]) thresh_q[t] <= wdata_i[$bits(prio_t)-1:0];
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // Per-target selection
    // ---------------------------------------------------------------------
    for (genvar t = 0; t < NumTargets; t++) begin : gen_target
        plic_target #(
            .NumSources ( NumSources )
        ) u_target (
            .prio_i      ( prio_q      ),
            .pending_i   ( pending_q   ),
            .enable_i    ( enable_q[t] ),
            .threshold_i ( thresh_q[t] ),
            .claim_id_o  ( claim_id[t] ),
            .eip_o       ( eip_o[t]    )
        );
    end

endmodule

/* timer/periph_timer.sv */
// ---------------------------------------------------------------------
// Compare timers
// Per timer count, compare and control registers
// Sticky match flag drives one interrupt source per timer
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module periph_timer #(
    parameter int NumTimers = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 sel_i,
    input  periph_pkg::offset_t  offset_i,
    input  logic                 write_i,
    input  periph_pkg::data_t    wdata_i,
    output periph_pkg::data_t    rdata_o,
    output logic [NumTimers-1:0] irq_o
);
    import periph_pkg::*;

    data_t [NumTimers-1:0] count_q;
    data_t [NumTimers-1:0] cmp_q;
    logic  [NumTimers-1:0] enable_q;  // Control bit 0
    logic  [NumTimers-1:0] flag_q;    // Control bit 1
    logic  [NumTimers-1:0] count_hit;
    logic  [NumTimers-1:0] cmp_hit;
    logic  [NumTimers-1:0] ctrl_hit;
    logic                  wr_en;

    assign wr_en = sel_i && write_i;
    assign irq_o = flag_q;

    always_comb begin
        offset_t base;
        for (int k = 0; k < NumTimers; k++) begin
            base         = offset_t'(TimerStride * k);
            count_hit[k] = (offset_i == base + TimerCountOffs);
            cmp_hit[k]   = (offset_i == base + TimerCmpOffs);
            ctrl_hit[k]  = (offset_i == base + TimerCtrlOffs);
        end
    end

    // Unknown offsets read 0
    always_comb begin
        rdata_o = '0;
        for (int k = 0; k < NumTimers; k++) begin
            if (count_hit[k]) rdata_o = count_q[k];
            if (cmp_hit[k])   rdata_o = cmp_q[k];
            if (ctrl_hit[k])  rdata_o = data_t'({flag_q[k], enable_q[k]});
        end
    end

    // ---------------------------------------------------------------------
    // Counters
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            cmp_q    <= '0;
            enable_q <= '0;
            flag_q   <= '0;
        end else begin
            for (int k = 0; k < NumTimers; k++) begin
                if (enable_q[k]) begin
                    if (count_q[k] == cmp_q[k]) begin
                        count_q[k] <= '0;
                        flag_q[k]  <= 1'b1;
                    end else begin
                        count_q[k] <= count_q[k] + 1'b1;
                    end
                end
                // Bus writes override the count update
                if (wr_en && count_hit[k]) count_q[k] <= wdata_i;
                if (wr_en && cmp_hit[k])   cmp_q[k]   <= wdata_i;
                if (wr_en && ctrl_hit[k]) begin
                    enable_q[k] <= wdata_i[0];
                    if (wdata_i[1]) flag_q[k] <= 1'b0;  // Write 1 to clear
                end
            end
        end
    end

endmodule

/* verilog/periph_decode.sv */
// ---------------------------------------------------------------------
// Register bus address decode
// Region select strobes, shared offset and write data
// Registered response with error responder for unmapped regions
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module periph_decode (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  periph_pkg::addr_t   req_addr_i,
    input  logic                req_write_i,
    input  periph_pkg::data_t   req_wdata_i,
    input  periph_pkg::data_t   plic_rdata_i,
    input  periph_pkg::data_t   timer_rdata_i,
    output logic                plic_sel_o,
    output logic                timer_sel_o,
    output periph_pkg::offset_t offset_o,
    output logic                write_o,
    output periph_pkg::data_t   wdata_o,
    output logic                rsp_valid_o,
    output periph_pkg::data_t   rsp_rdata_o,
    output logic                rsp_error_o
);
    import periph_pkg::*;

    region_t region;
    logic    hit;
    data_t   rdata_d;

    assign region   = req_addr_i[15:12];
    assign offset_o = req_addr_i[11:0];
    assign write_o  = req_write_i;
    assign wdata_o  = req_wdata_i;

    // One strobe per mapped block
    assign plic_sel_o  = req_valid_i && (region == RegionPlic);
    assign timer_sel_o = req_valid_i && (region == RegionTimer);
    assign hit         = plic_sel_o || timer_sel_o;

    always_comb begin
        if (!hit) begin
            rdata_d = ErrData;
        end else if (req_write_i) begin
            rdata_d = '0;
        end else if (plic_sel_o) begin
            rdata_d = plic_rdata_i;
        end else begin
            rdata_d = timer_rdata_i;
        end
    end

    // Response one cycle after the request
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_error_o <= 1'b0;
            rsp_rdata_o <= '0;
        end else begin
            rsp_valid_o <= req_valid_i;
            if (req_valid_i) begin
                rsp_error_o <= !hit;  // Reads and writes alike
                rsp_rdata_o <= rdata_d;
            end
        end
    end

endmodule

/* verilog/periph_top.sv */
// ---------------------------------------------------------------------
// Peripheral subsystem top level
// Register bus decode, interrupt controller and compare timers
// ---------------------------------------------------------------------

`timescale 1ns/100ps

module periph_top #(
    parameter int NumExtIrq  = 2,
    parameter int NumTimers  = 2,
    parameter int NumTargets = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  periph_pkg::addr_t     req_addr_i,
    input  logic                  req_write_i,
    input  periph_pkg::data_t     req_wdata_i,
    input  logic [NumExtIrq-1:0]  ext_irq_i,
    output logic                  rsp_valid_o,
    output periph_pkg::data_t     rsp_rdata_o,
    output logic                  rsp_error_o,
    output logic [NumTargets-1:0] eip_o
);
    import periph_pkg::*;

    localparam int NumSources = NumExtIrq + NumTimers;

    logic                 plic_sel;
    logic                 timer_sel;
    offset_t              offset;
    logic                 write;
    data_t                wdata;
    data_t                plic_rdata;
    data_t                timer_rdata;
    logic [NumTimers-1:0] timer_irq;

    periph_decode u_decode (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_addr_i    ( req_addr_i  ),
        .req_write_i   ( req_write_i ),
        .req_wdata_i   ( req_wdata_i ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .offset_o      ( offset      ),
        .write_o       ( write       ),
        .wdata_o       ( wdata       ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_error_o   ( rsp_error_o )
    );

    // External sources take the low IDs, timers follow
    plic_regs #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) u_plic (
        .clk_i     ( clk_i                    ),
        .rst_n_i   ( rst_n_i                  ),
        .sel_i     ( plic_sel                 ),
        .offset_i  ( offset                   ),
        .write_i   ( write                    ),
        .wdata_i   ( wdata                    ),
        .irq_src_i ( {timer_irq, ext_irq_i}   ),
        .rdata_o   ( plic_rdata               ),
        .eip_o     ( eip_o                    )
    );

    periph_timer #(
        .NumTimers ( NumTimers )
    ) u_timer (
        .clk_i    ( clk_i       ),
        .rst_n_i  ( rst_n_i     ),
        .sel_i    ( timer_sel   ),
        .offset_i ( offset      ),
        .write_i  ( write       ),
        .wdata_i  ( wdata       ),
        .rdata_o  ( timer_rdata ),
        .irq_o    ( timer_irq   )
    );

endmodule

/* test/tb_periph_tests.svh */
// ----------------------------------------------------------------------
// Directed tests for the peripheral subsystem
// Address helpers, interrupt line checks and one task per behavior
// ----------------------------------------------------------------------

function automatic addr_t plic_addr(input offset_t offs);
    return PlicBase + addr_t'(offs);
endfunction

function automatic addr_t prio_addr(input int id);
    return PlicBase + addr_t'(4 * id);  // Source ID s at 4*s
endfunction

function automatic addr_t enable_addr(input int t);
    return plic_addr(PlicEnableOffs) + addr_t'(4 * t);
endfunction

function automatic addr_t thresh_addr(input int t);
    return plic_addr(PlicThreshOffs) + addr_t'(8 * t);
endfunction

function automatic addr_t claim_addr(input int t);
    return plic_addr(PlicClaimOffs) + addr_t'(8 * t);
endfunction

function automatic addr_t timer_addr(input int k, input offset_t offs);
    return TimerBase + addr_t'(TimerStride * k) + addr_t'(offs);
endfunction

task automatic check_eip(input int t, input logic exp);
    check_value($sformatf("eip_o[%0d]", t), data_t'(eip[t]), data_t'(exp));
endtask

task automatic wait_for_eip(input int t, input int max_cycles);
    int n;
    n = 0;
    while (eip[t] !== 1'b1 && n < max_cycles) begin
        @(negedge clk);
        n++;
    end
    assert (eip[t] === 1'b1) else begin
        $display("Interrupt line eip_o[%0d] did not rise within %0d cycles", t, max_cycles);
        stop_run();
    end
endtask

task automatic check_eip_low_for(input int t, input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_eip(t, 1'b0);
    end
endtask

task automatic clear_plic_config();
    for (int s = 1; s <= NumSources; s++) bus_write(prio_addr(s), '0);
    for (int t = 0; t < NumTargets; t++) begin
        bus_write(enable_addr(t), '0);
        bus_write(thresh_addr(t), '0);
    end
endtask

// ----------------------------------------------------------------------
// Tests
// ----------------------------------------------------------------------
task automatic test_decode();
    @(negedge clk);
    drive_request(32'h0000_2010, 1'b0, '0);  // Read region 2
    @(negedge clk);
    check_response(1'b1, ErrData);
    drive_request(32'h0000_F004, 1'b1, 32'h1234_5678);  // Write region 15
    @(negedge clk);
    check_response(1'b1, ErrData);
    drive_request(32'h0000_2000, 1'b1, 32'hA5A5_A5A5);
    @(negedge clk);
    check_response(1'b1, ErrData);
    drive_request(32'h0000_F000, 1'b0, '0);
    @(negedge clk);
    check_response(1'b1, ErrData);
    drive_idle();
    @(negedge clk);
    check_value("rsp_valid_o", data_t'(rsp_valid), 32'd0);
    // Mapped regions answer without error
    read_expect(plic_addr(PlicPendingOffs), 32'h0);
    bus_write(timer_addr(0, TimerCmpOffs), 32'h55);
    read_expect(timer_addr(0, TimerCmpOffs), 32'h55);
    bus_write(timer_addr(0, TimerCmpOffs), '0);
endtask

task automatic test_readback();
    data_t wdata;
    data_t enable_mask;
    enable_mask = ((32'h1 << NumSources) - 1) << 1;  // Bit s is source ID s
    for (int s = 1; s <= NumSources; s++) begin
        wdata = $urandom;
        bus_write(prio_addr(s), wdata);
        read_expect(prio_addr(s), wdata & 32'h7);
    end
    for (int t = 0; t < NumTargets; t++) begin
        wdata = $urandom;
        bus_write(enable_addr(t), wdata);
        read_expect(enable_addr(t), wdata & enable_mask);
        wdata = $urandom;
        bus_write(thresh_addr(t), wdata);
        read_expect(thresh_addr(t), wdata & 32'h7);
    end
    bus_write(plic_addr(12'h300), 32'hFFFF_FFFF);
    read_expect(plic_addr(12'h300), '0);
    read_expect(prio_addr(0), '0);  // No source ID 0
    read_expect(prio_addr(NumSources + 1), '0);
    bus_write(timer_addr(NumTimers, TimerCountOffs), 32'hFFFF_FFFF);
    read_expect(timer_addr(NumTimers, TimerCountOffs), '0);
    read_expect(timer_addr(0, 12'h00C), '0);
    clear_plic_config();
endtask

task automatic test_claim();
    bus_write(prio_addr(1), 32'd3);
    bus_write(prio_addr(2), 32'd3);
    bus_write(thresh_addr(0), 32'd1);
    bus_write(enable_addr(0), 32'h6);  // IDs 1 and 2, target 0 only
    @(negedge clk);
    ext_irq = 2'b11;
    wait_for_eip(0, 4);
    check_eip(1, 1'b0);
    read_expect(claim_addr(0), 32'd1);  // Tie goes to the lower ID
    check_eip(0, 1'b1);
    read_expect(claim_addr(0), 32'd2);
    read_expect(claim_addr(0), 32'd0);
    check_eip_low_for(0, 5);  // Both in service
    read_expect(plic_addr(PlicPendingOffs), 32'h0);
    bus_write(claim_addr(0), 32'd1);
    wait_for_eip(0, 4);
    read_expect(plic_addr(PlicPendingOffs), 32'h2);
    read_expect(claim_addr(0), 32'd1);
    @(negedge clk);
    ext_irq = '0;
    bus_write(claim_addr(0), 32'd1);
    bus_write(claim_addr(0), 32'd2);
    check_eip_low_for(0, 3);
    check_eip(1, 1'b0);
    read_expect(plic_addr(PlicPendingOffs), 32'h0);
    clear_plic_config();
endtask

task automatic test_threshold();
    bus_write(prio_addr(1), 32'd2);
    bus_write(thresh_addr(0), 32'd2);
    bus_write(enable_addr(0), 32'h2);
    @(negedge clk);
    ext_irq = 2'b01;
    check_eip_low_for(0, 5);  // Equal to threshold is not enough
    read_expect(plic_addr(PlicPendingOffs), 32'h2);
    read_expect(claim_addr(0), 32'd0);
    bus_write(prio_addr(1), 32'd3);
    wait_for_eip(0, 4);
    read_expect(claim_addr(0), 32'd1);
    @(negedge clk);
    ext_irq = '0;
    bus_write(claim_addr(0), 32'd1);
    check_eip_low_for(0, 3);
    clear_plic_config();
endtask

task automatic test_timer();
    data_t rdata;
    int    waited;
    logic  found;
    bus_write(prio_addr(NumExtIrq + 2), 32'd5);
    bus_write(enable_addr(1), 32'h1 << (NumExtIrq + 2));
    bus_write(timer_addr(1, TimerCmpOffs), 32'd20);
    bus_write(timer_addr(1, TimerCountOffs), '0);
    bus_write(timer_addr(1, TimerCtrlOffs), 32'h1);
    waited = 0;
    found  = 1'b0;
    while (!found && waited < 30) begin
        bus_read(timer_addr(1, TimerCtrlOffs), rdata);
        waited += 2;  // Two cycles per poll
        found = rdata[1];
    end
    assert (found) else begin
        $display("Timer 1 match flag was not set within 30 cycles");
        stop_run();
    end
    check_value("rsp_rdata_o (timer 1 control)", rdata, 32'h3);
    wait_for_eip(1, 4);
    check_eip(0, 1'b0);
    read_expect(claim_addr(1), data_t'(NumExtIrq + 2));
    bus_write(timer_addr(1, TimerCtrlOffs), 32'h2);  // Disable and clear flag
    bus_write(claim_addr(1), data_t'(NumExtIrq + 2));
    check_eip_low_for(1, 3);
    read_expect(timer_addr(1, TimerCtrlOffs), 32'h0);
    read_expect(plic_addr(PlicPendingOffs), 32'h0);
    clear_plic_config();
endtask

/* test/tb_periph.sv */
// ----------------------------------------------------------------------
// Testbench for the peripheral subsystem
// Clock, reset, DUT, cycle timeout and register bus tasks
// Directed tests come from the included test file
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_periph;
    import periph_pkg::*;

    localparam int    NumExtIrq     = 2;
    localparam int    NumTimers     = 2;
    localparam int    NumTargets    = 2;
    localparam int    NumSources    = NumExtIrq + NumTimers;
    localparam int    ClkPeriod     = 4;
    localparam int    RandSeed      = 26;
    localparam int    TimeoutCycles = 5000;  // Tests need a few hundred cycles
    localparam addr_t PlicBase      = 32'h0000_0000;
    localparam addr_t TimerBase     = 32'h0000_1000;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    addr_t                 req_addr;
    logic                  req_write;
    data_t                 req_wdata;
    logic [NumExtIrq-1:0]  ext_irq;
    logic                  rsp_valid;
    data_t                 rsp_rdata;
    logic                  rsp_error;
    logic [NumTargets-1:0] eip;
    int                    cycle_count;

    periph_top #(
        .NumExtIrq  ( NumExtIrq  ),
        .NumTimers  ( NumTimers  ),
        .NumTargets ( NumTargets )
    ) u_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_addr_i  ( req_addr  ),
        .req_write_i ( req_write ),
        .req_wdata_i ( req_wdata ),
        .ext_irq_i   ( ext_irq   ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_error_o ( rsp_error ),
        .eip_o       ( eip       )
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Error handling and timeout
    // ----------------------------------------------------------------------
    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            stop_run();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TimeoutCycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", TimeoutCycles);
        stop_run();
    end

    // ----------------------------------------------------------------------
    // Register bus
    // ----------------------------------------------------------------------
    task automatic drive_request(input addr_t addr, input logic write, input data_t wdata);
        req_valid = 1'b1;
        req_addr  = addr;
        req_write = write;
        req_wdata = wdata;
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        req_write = 1'b0;
    endtask

    task automatic check_response(input logic exp_error, input data_t exp_rdata);
        check_value("rsp_valid_o", data_t'(rsp_valid), 32'd1);
        check_value("rsp_error_o", data_t'(rsp_error), data_t'(exp_error));
        check_value("rsp_rdata_o", rsp_rdata, exp_rdata);
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata);
        @(negedge clk);
        drive_request(addr, 1'b1, wdata);
        @(negedge clk);  // Response one cycle later
        drive_idle();
        check_response(1'b0, '0);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        @(negedge clk);
        drive_request(addr, 1'b0, '0);
        @(negedge clk);
        drive_idle();
        check_value("rsp_valid_o", data_t'(rsp_valid), 32'd1);
        check_value("rsp_error_o", data_t'(rsp_error), 32'd0);
        rdata = rsp_rdata;
    endtask

    task automatic read_expect(input addr_t addr, input data_t exp);
        data_t rdata;
        bus_read(addr, rdata);
        check_value($sformatf("rsp_rdata_o (addr 0x%08h)", addr), rdata, exp);
    endtask

    `include "tb_periph_tests.svh"

    initial begin
        void'($urandom(RandSeed));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_wdata = '0;
        ext_irq   = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("rsp_valid_o", data_t'(rsp_valid), 32'd0);
        check_value("eip_o", data_t'(eip), 32'd0);

        test_decode();
        test_readback();
        test_claim();
        test_threshold();
        test_timer();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+test
common/periph_pkg.sv
plic/plic_target.sv
plic/plic_regs.sv
timer/periph_timer.sv
verilog/periph_decode.sv
verilog/periph_top.sv
test/tb_periph.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_periph -f sim.f

# The simulator exits non-zero on $fatal, the output decides the result
sim_out=$(./obj_dir/Vtb_periph 2>&1 || true)
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
